// ==== source/aznable_pkg.sv ====
package aznable_pkg;

	// cpu bus
	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// decoded i/o regions
	typedef enum logic [3:0]
	{
		REGION_NONE,
		REGION_IN0,
		REGION_VIDEO_CTL,
		REGION_TIMESTAMP,
		REGION_TIMER,
		REGION_JOYSTICK,
		REGION_PADDLE,
		REGION_PS2_KEY,
		REGION_PAUSE,
		REGION_MENU
	} region_t;

	// four-phase responder states
	typedef enum logic {BUS_IDLE, BUS_ACK} bus_state_t;

	// i/o page address map with half-open [base, end) windows
	localparam addr_t IN0_ADDR = 16'h8000;
	localparam addr_t VIDEO_CTL_ADDR = 16'h8001;
	localparam addr_t TIMESTAMP_BASE = 16'h8080;
	localparam addr_t TIMESTAMP_END = 16'h80A0;
	localparam addr_t TIMER_BASE = 16'h80C0;
	localparam addr_t TIMER_END = 16'h80D0;
	localparam addr_t JOYSTICK_BASE = 16'h8100;
	localparam addr_t JOYSTICK_END = 16'h81C0;
	localparam addr_t PADDLE_BASE = 16'h8300;
	localparam addr_t PADDLE_END = 16'h8330;
	localparam addr_t PS2_KEY_BASE = 16'h8400;
	localparam addr_t PS2_KEY_END = 16'h840C;
	localparam addr_t PAUSE_ADDR = 16'h8530;
	localparam addr_t MENU_ADDR = 16'h8531;

	// input vector widths
	// joystick carries 6 devices of 32 buttons
	localparam int JOYSTICK_W = 192;
	localparam int PADDLE_W = 48;
	localparam int PS2_KEY_W = 11;
	localparam int TIMESTAMP_W = 33;
	localparam int TIMER_W = 16;

	// byte index within a window of up to 32 bytes
	localparam int OFFSET_W = 5;

endpackage

// ==== source/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
	input aznable_pkg::addr_t addr,
	output aznable_pkg::region_t region,
	output logic [aznable_pkg::OFFSET_W-1:0] offset
);

	import aznable_pkg::*;

	always_comb
	begin
		region = REGION_NONE;
		offset = '0;
		if (addr == IN0_ADDR)
			region = REGION_IN0;
		else if (addr == VIDEO_CTL_ADDR)
			region = REGION_VIDEO_CTL;
		else if (addr >= TIMESTAMP_BASE && addr < TIMESTAMP_END)
		begin
			// only the low 3 bits index the timestamp bytes
			region = REGION_TIMESTAMP;
			offset = OFFSET_W'(addr[2:0]);
		end
		else if (addr >= TIMER_BASE && addr < TIMER_END)
		begin
			region = REGION_TIMER;
			offset = OFFSET_W'(addr[0]);
		end
		else if (addr >= JOYSTICK_BASE && addr < JOYSTICK_END)
		begin
			region = REGION_JOYSTICK;
			offset = addr[4:0];
		end
		else if (addr >= PADDLE_BASE && addr < PADDLE_END)
		begin
			region = REGION_PADDLE;
			offset = OFFSET_W'(addr[2:0]);
		end
		else if (addr >= PS2_KEY_BASE && addr < PS2_KEY_END)
		begin
			region = REGION_PS2_KEY;
			offset = OFFSET_W'(addr[0]);
		end
		else if (addr == PAUSE_ADDR)
			region = REGION_PAUSE;
		else if (addr == MENU_ADDR)
			region = REGION_MENU;
	end

endmodule

// ==== source/bus_responder.sv ====
`timescale 1ns/1ps

module bus_responder (
	input logic clk_24,
	input logic rst_n,
	input logic bus_req,
	input logic bus_wr,
	input aznable_pkg::data_t read_byte,
	output logic wr_strobe,
	output logic bus_ack,
	output aznable_pkg::data_t bus_rdata
);

	import aznable_pkg::*;

	bus_state_t state;
	bus_state_t state_next;

	// accepting edge is the first one that sees req high while idle
	logic accept;

	assign accept = (state == BUS_IDLE) && bus_req;

	// high in the cycle before the accepting edge, so the register
	// write lands on the same edge that raises ack
	assign wr_strobe = accept && bus_wr;

	always_comb
	begin
		state_next = state;
		case (state)
			BUS_IDLE:
			begin
				if (bus_req)
					state_next = BUS_ACK;
			end
			BUS_ACK:
			begin
				// hold ack until the cpu lets go of req
				if (!bus_req)
					state_next = BUS_IDLE;
			end
			default:
			begin
				state_next = BUS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			state <= BUS_IDLE;
			bus_ack <= 1'b0;
		end
		else
		begin
			state <= state_next;
			bus_ack <= (state_next == BUS_ACK);
		end
	end

	// read data is captured once per access and then held
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			bus_rdata <= 8'h00;
		else if (accept && !bus_wr)
			bus_rdata <= read_byte;
	end

endmodule

// ==== source/ms_timer.sv ====
`timescale 1ns/1ps

module ms_timer #(
	parameter int CLK_PER_MS = 24000
) (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::region_t region,
	input logic wr_strobe,
	output logic [aznable_pkg::TIMER_W-1:0] timer_count
);

	import aznable_pkg::*;

	localparam int PRE_W = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;

	logic [PRE_W-1:0] prescale;
	logic clear;
	logic tick;

	// any write into the timer window restarts the count
	assign clear = wr_strobe && (region == REGION_TIMER);
	assign tick = (prescale == PRE_W'(CLK_PER_MS - 1));

	always_ff @(posedge clk_24)
	begin
		if (!rst_n || clear)
		begin
			prescale <= '0;
			timer_count <= '0;
		end
		else if (tick)
		begin
			prescale <= '0;
			timer_count <= timer_count + 1'b1;
		end
		else
			prescale <= prescale + 1'b1;
	end

endmodule

// ==== source/system_regs.sv ====
`timescale 1ns/1ps

module system_regs (
	input logic clk_24,
	input logic rst_n,
	input aznable_pkg::region_t region,
	input logic wr_strobe,
	input aznable_pkg::data_t wdata,
	input logic pause,
	input logic menu,
	output aznable_pkg::data_t video_control,
	output logic sprite_layer_high,
	output logic pause_out,
	output logic menu_pending
);

	import aznable_pkg::*;

	logic pause_trigger;

	// bit 0 of video control puts sprites above the charmap
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			video_control <= 8'h00;
		else if (wr_strobe && region == REGION_VIDEO_CTL)
			video_control <= wdata;
	end

	assign sprite_layer_high = video_control[0];

	// software pause request, dropped once the host pause input arrives
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			pause_trigger <= 1'b0;
		else if (pause)
			pause_trigger <= 1'b0;
		else if (wr_strobe && region == REGION_PAUSE)
			pause_trigger <= 1'b1;
	end

	assign pause_out = pause || pause_trigger;

	// menu request stays pending until software acknowledges it
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			menu_pending <= 1'b0;
		else if (menu)
			menu_pending <= 1'b1;
		else if (wr_strobe && region == REGION_MENU)
			menu_pending <= 1'b0;
	end

endmodule

// ==== source/input_mux.sv ====
`timescale 1ns/1ps

module input_mux (
	input aznable_pkg::region_t region,
	input logic [aznable_pkg::OFFSET_W-1:0] offset,
	input logic [aznable_pkg::JOYSTICK_W-1:0] joystick,
	input logic [aznable_pkg::PADDLE_W-1:0] paddle,
	input logic [aznable_pkg::PS2_KEY_W-1:0] ps2_key,
	input logic [aznable_pkg::TIMESTAMP_W-1:0] timestamp,
	input logic [aznable_pkg::TIMER_W-1:0] timer_count,
	input logic menu,
	input logic menu_pending,
	output aznable_pkg::data_t read_byte
);

	import aznable_pkg::*;

	// every vector is zero padded to the full 32-byte window
	localparam int VEC_W = 8 << OFFSET_W;

	function automatic data_t select_byte(
		input logic [VEC_W-1:0] vec,
		input logic [OFFSET_W-1:0] idx
	);
		return vec[{idx, 3'b000} +: 8];
	endfunction

	always_comb
	begin
		case (region)
			// bit 3 is fixed high and bit 1 mirrors the menu input
			REGION_IN0:
				read_byte = {4'b0000, 1'b1, 1'b0, menu, 1'b0};
			REGION_TIMESTAMP:
				read_byte = select_byte(VEC_W'(timestamp), offset);
			REGION_TIMER:
				read_byte = select_byte(VEC_W'(timer_count), offset);
			REGION_JOYSTICK:
				read_byte = select_byte(VEC_W'(joystick), offset);
			REGION_PADDLE:
				read_byte = select_byte(VEC_W'(paddle), offset);
			REGION_PS2_KEY:
				read_byte = select_byte(VEC_W'(ps2_key), offset);
			REGION_MENU:
				read_byte = {8{menu_pending}};
			// video control and pause are write only
			default:
				read_byte = 8'h00;
		endcase
	end

endmodule

// ==== source/aznable_io.sv ====
`timescale 1ns/1ps

module aznable_io #(
	parameter int CLK_PER_MS = 24000
) (
	input logic clk_24,
	input logic rst_n,

	// four-phase req/ack cpu bus
	input logic bus_req,
	input logic bus_wr,
	input aznable_pkg::addr_t bus_addr,
	input aznable_pkg::data_t bus_wdata,
	output logic bus_ack,
	output aznable_pkg::data_t bus_rdata,

	// host inputs
	input logic [aznable_pkg::JOYSTICK_W-1:0] joystick,
	input logic [aznable_pkg::PADDLE_W-1:0] paddle,
	input logic [aznable_pkg::PS2_KEY_W-1:0] ps2_key,
	input logic [aznable_pkg::TIMESTAMP_W-1:0] timestamp,
	input logic pause,
	input logic menu,

	output logic pause_out,
	output logic sprite_layer_high
);

	import aznable_pkg::*;

	region_t region;
	logic [OFFSET_W-1:0] offset;
	logic wr_strobe;
	data_t read_byte;
	logic menu_pending;
	logic [TIMER_W-1:0] timer_count;

	addr_decoder decoder_i (
		.addr(bus_addr),
		.region(region),
		.offset(offset)
	);

	bus_responder responder_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.bus_req(bus_req),
		.bus_wr(bus_wr),
		.read_byte(read_byte),
		.wr_strobe(wr_strobe),
		.bus_ack(bus_ack),
		.bus_rdata(bus_rdata)
	);

	ms_timer #(
		.CLK_PER_MS(CLK_PER_MS)
	) timer_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.region(region),
		.wr_strobe(wr_strobe),
		.timer_count(timer_count)
	);

	// only bit 0 of video control leaves this block
	system_regs regs_i (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.region(region),
		.wr_strobe(wr_strobe),
		.wdata(bus_wdata),
		.pause(pause),
		.menu(menu),
		.video_control(),
		.sprite_layer_high(sprite_layer_high),
		.pause_out(pause_out),
		.menu_pending(menu_pending)
	);

	input_mux mux_i (
		.region(region),
		.offset(offset),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.timer_count(timer_count),
		.menu(menu),
		.menu_pending(menu_pending),
		.read_byte(read_byte)
	);

endmodule

// ==== sim/tb_aznable_io.sv ====
`timescale 1ns/1ps

module tb_aznable_io;

	import aznable_pkg::*;

	typedef enum logic [3:0]
	{
		OP_READ, OP_WRITE, OP_HOLD, OP_WAIT, OP_PULSE_PAUSE,
		OP_PULSE_MENU, OP_TIMER_READ, OP_SPRITE, OP_PAUSE_OUT, OP_MENU_READ
	} op_t;

	// wdata doubles as the hold or wait cycle count
	// exp[0] is the expected level for bit checks
	typedef struct packed
	{
		op_t op;
		addr_t addr;
		data_t wdata;
		data_t exp;
	} entry_t;

	localparam addr_t UNMAPPED[11] = '{16'h0000, 16'h7FFF, 16'h8002, 16'h80A0, 16'h80D0,
		16'h81C0, 16'h8330, 16'h840C, 16'h8532, 16'hFFFF, VIDEO_CTL_ADDR};

	logic clk_24, rst_n, bus_req, bus_wr, bus_ack, pause, menu, pause_out, sprite_layer_high;
	addr_t bus_addr;
	data_t bus_wdata, bus_rdata;
	logic [JOYSTICK_W-1:0] joystick;
	logic [PADDLE_W-1:0] paddle;
	logic [PS2_KEY_W-1:0] ps2_key;
	logic [TIMESTAMP_W-1:0] timestamp;

	entry_t table_q[$];
	bit table_ready = 1'b0;
	int tests = 0;
	int errors = 0;
	int cycle_cnt = 0;
	int last_ack_cycle;
	int write_ack_cycle;

	aznable_io #(.CLK_PER_MS(8)) dut_i (.*);

	initial clk_24 = 1'b0;
	always #5 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle_cnt <= cycle_cnt + 1;

	// byte n of a vector with zeros past its width
	function automatic data_t byte_of(input logic [255:0] vec, input int width, input int n);
		data_t b;
		for (int i = 0; i < 8; i++)
			b[i] = (8 * n + i < width) ? vec[8 * n + i] : 1'b0;
		return b;
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		tests++;
		if (got === exp)
			$display("ok %s = %h", name, got);
		else
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		tests++;
		if (got === exp)
			$display("ok %s = %h", name, got);
		else
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_handshake(input string what, input logic ok);
		tests++;
		if (ok)
			$display("ok %s", what);
		else
		begin
			errors++;
			$display("handshake violation: expected %s, but it did not happen", what);
		end
	endtask

	// one four-phase access that holds req for extra cycles once ack is seen
	task automatic access(input logic wr, input addr_t addr, input data_t wdata, input int hold);
		int waited;
		data_t held;
		waited = 0;
		bus_wr = wr;
		bus_addr = addr;
		bus_wdata = wdata;
		bus_req = 1'b1;
		do
		begin
			@(posedge clk_24);
			#1;
			waited++;
		end while (!bus_ack && waited < 8);
		check_handshake("ack 1 cycle after req is sampled", bus_ack && waited == 1);
		last_ack_cycle = cycle_cnt;
		held = bus_rdata;
		repeat (hold)
		begin
			@(posedge clk_24);
			#1;
			check_bit("bus_ack while req held", bus_ack, 1'b1);
			check_data("bus_rdata while req held", bus_rdata, held);
		end
		bus_req = 1'b0;
		@(posedge clk_24);
		#1;
		check_handshake("ack low 1 cycle after req drops", !bus_ack);
	endtask

	task automatic add(input op_t op, input addr_t addr, input data_t wdata, input data_t exp);
		table_q.push_back('{op, addr, wdata, exp});
	endtask

	task automatic build_table();
		add(OP_READ, MENU_ADDR, 8'h00, 8'h00);
		add(OP_READ, IN0_ADDR, 8'h00, 8'h08);
		add(OP_READ, PAUSE_ADDR, 8'h00, 8'h00);
		for (int i = 0; i < 11; i++)
			add(OP_READ, UNMAPPED[i], 8'h00, 8'h00);
		// joystick window repeats every 32 bytes
		for (int i = 0; i < 32; i++)
			add(OP_READ, addr_t'(JOYSTICK_BASE + i), 8'h00, byte_of(joystick, JOYSTICK_W, i));
		add(OP_READ, 16'h8123, 8'h00, byte_of(joystick, JOYSTICK_W, 3));
		for (int i = 0; i < 8; i++)
		begin
			add(OP_READ, addr_t'(TIMESTAMP_BASE + i), 8'h00, byte_of(timestamp, TIMESTAMP_W, i));
			add(OP_READ, addr_t'(PADDLE_BASE + i), 8'h00, byte_of(paddle, PADDLE_W, i));
		end
		add(OP_READ, 16'h809A, 8'h00, byte_of(timestamp, TIMESTAMP_W, 2));
		add(OP_READ, 16'h832D, 8'h00, byte_of(paddle, PADDLE_W, 5));
		add(OP_READ, PS2_KEY_BASE, 8'h00, byte_of(ps2_key, PS2_KEY_W, 0));
		add(OP_READ, 16'h840B, 8'h00, byte_of(ps2_key, PS2_KEY_W, 1));
		add(OP_HOLD, 16'h8105, 8'd4, byte_of(joystick, JOYSTICK_W, 5));
		add(OP_WRITE, VIDEO_CTL_ADDR, 8'h81, 8'h00);
		add(OP_SPRITE, 16'h0000, 8'h00, 8'h01);
		add(OP_WRITE, VIDEO_CTL_ADDR, 8'hFE, 8'h00);
		add(OP_SPRITE, 16'h0000, 8'h00, 8'h00);
		add(OP_WRITE, PAUSE_ADDR, 8'h01, 8'h00);
		add(OP_PAUSE_OUT, 16'h0000, 8'h00, 8'h01);
		add(OP_PULSE_PAUSE, 16'h0000, 8'h00, 8'h00);
		add(OP_PAUSE_OUT, 16'h0000, 8'h00, 8'h00);
		add(OP_PULSE_MENU, 16'h0000, 8'h00, 8'h00);
		add(OP_READ, MENU_ADDR, 8'h00, 8'hFF);
		add(OP_WRITE, MENU_ADDR, 8'h00, 8'h00);
		add(OP_READ, MENU_ADDR, 8'h00, 8'h00);
		// in0 bit 1 follows the menu input while it is held
		add(OP_MENU_READ, IN0_ADDR, 8'h00, 8'h0A);
		add(OP_WRITE, 16'h80C3, 8'h55, 8'h00);
		add(OP_WAIT, 16'h0000, 8'd29, 8'h00);
		add(OP_TIMER_READ, TIMER_BASE, 8'h00, 8'h00);
	endtask

	initial
	begin
		entry_t e;
		void'($urandom(59));
		for (int i = 0; i < 6; i++)
			joystick[32 * i +: 32] = $urandom();
		paddle = {16'($urandom()), 32'($urandom())};
		ps2_key = 11'($urandom());
		timestamp = {1'($urandom()), 32'($urandom())};
		rst_n = 1'b0;
		bus_req = 1'b0;
		bus_wr = 1'b0;
		bus_addr = 16'h0000;
		bus_wdata = 8'h00;
		pause = 1'b0;
		menu = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk_24);
		#1;
		rst_n = 1'b1;
		check_bit("bus_ack", bus_ack, 1'b0);
		check_bit("sprite_layer_high", sprite_layer_high, 1'b0);
		check_bit("pause_out", pause_out, 1'b0);
		foreach (table_q[k])
		begin
			e = table_q[k];
			case (e.op)
				OP_READ, OP_HOLD, OP_MENU_READ:
				begin
					menu = (e.op == OP_MENU_READ);
					access(1'b0, e.addr, 8'h00, (e.op == OP_HOLD) ? int'(e.wdata) : 0);
					menu = 1'b0;
					check_data($sformatf("bus_rdata @%h", e.addr), bus_rdata, e.exp);
				end
				OP_WRITE:
				begin
					access(1'b1, e.addr, e.wdata, 0);
					write_ack_cycle = last_ack_cycle;
				end
				OP_WAIT:
					repeat (e.wdata) @(posedge clk_24);
				OP_PULSE_PAUSE, OP_PULSE_MENU:
				begin
					pause = (e.op == OP_PULSE_PAUSE);
					menu = (e.op == OP_PULSE_MENU);
					@(posedge clk_24);
					#1;
					pause = 1'b0;
					menu = 1'b0;
					@(posedge clk_24);
				end
				OP_TIMER_READ:
				begin
					access(1'b0, e.addr, 8'h00, 0);
					// the ack edge captures the count left by the edge before it
					check_data("timer_count low byte", bus_rdata,
						data_t'((last_ack_cycle - write_ack_cycle - 1) / 8));
				end
				OP_SPRITE:
					check_bit("sprite_layer_high", sprite_layer_high, e.exp[0]);
				default:
					check_bit("pause_out", pause_out, e.exp[0]);
			endcase
			if (e.op == OP_WAIT || e.op == OP_PULSE_PAUSE || e.op == OP_PULSE_MENU)
				#1;
		end
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// run length scales with the table
	initial
	begin
		wait (table_ready);
		repeat (table_q.size() * 20 + 200) @(posedge clk_24);
		$display("timeout: the test table did not finish in the expected number of cycles");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== aznable_io.f ====
source/aznable_pkg.sv
source/addr_decoder.sv
source/bus_responder.sv
source/ms_timer.sv
source/system_regs.sv
source/input_mux.sv
source/aznable_io.sv
sim/tb_aznable_io.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f aznable_io.f \
	--top-module tb_aznable_io -o sim_aznable_io
out=$(./obj_dir/sim_aznable_io)
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
